//--- source/sldu_pkg.sv
/*
  Shared definitions of the slide unit
  Lane, word, register and queue sizes
  Data, byte enable, id, address and byte count types
  Element width and slide direction encodings, sequencer request
*/
package sldu_pkg;

  //////////////////////////////
  // Sizes
  //////////////////////////////

  // Two lanes of 64 bits make one vector word
  localparam int unsigned NrLanes          = 2;
  localparam int unsigned LaneBytes        = 8;
  localparam int unsigned WordBytes        = NrLanes * LaneBytes;
  // A vector register spans this many vector words
  localparam int unsigned WordsPerReg      = 4;
  localparam int unsigned NrVInsn          = 8;
  localparam int unsigned InsnQueueDepth   = 2;
  localparam int unsigned ResultQueueDepth = 2;

  // Pointer widths
  // Byte pointers must also hold WordBytes itself
  localparam int unsigned BytePntWidth     = $clog2(WordBytes) + 1;
  localparam int unsigned InsnPntWidth     = $clog2(InsnQueueDepth);
  localparam int unsigned RqPntWidth       = $clog2(ResultQueueDepth);

  //////////////////////////////
  // Types
  //////////////////////////////

  typedef logic [8*LaneBytes-1:0]     elen_t;
  typedef logic [LaneBytes-1:0]       strb_t;
  typedef logic [$clog2(NrVInsn)-1:0] vid_t;
  typedef logic [7:0]                 vaddr_t;
  // Byte or element count
  typedef logic [7:0]                 vlen_t;
  typedef logic [BytePntWidth-1:0]    bpnt_t;

  // Element width, also the log2 of the bytes per element
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } elem_width_e;

  typedef enum logic {
    SLIDE_UP   = 1'b0,
    SLIDE_DOWN = 1'b1
  } slide_op_e;

  // Request from the sequencer
  typedef struct packed {
    vid_t        id;
    slide_op_e   op;
    elem_width_e vsew;
    vlen_t       vl;      // in elements
    vlen_t       stride;  // in elements, below vl
    logic [4:0]  vd;
  } slide_req_t;

endpackage

//--- source/slide_insn_queue.sv
/*
  Instruction queue of the slide unit
  Accept, issue and commit pointers with their counters
  Registered issue request toward the byte engine
  Done pulse per instruction id
*/
`timescale 1ns/1ps

module slide_insn_queue (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  sldu_pkg::slide_req_t         req_i,
  input  logic                         req_valid_i,
  output logic                         req_ready_o,
  output sldu_pkg::slide_req_t         issue_req_o,
  output logic                         issue_valid_o,
  input  logic                         issue_done_i,
  input  logic                         commit_done_i,
  input  sldu_pkg::vid_t               commit_id_i,
  output logic [sldu_pkg::NrVInsn-1:0] done_o
);
  import sldu_pkg::*;

  // Stored requests
  slide_req_t [InsnQueueDepth-1:0] slot_q;

  // One pointer per phase, wrapping at the depth
  logic [InsnPntWidth-1:0] accept_pnt_d, accept_pnt_q;
  logic [InsnPntWidth-1:0] issue_pnt_d, issue_pnt_q;
  logic [InsnPntWidth-1:0] commit_pnt_d, commit_pnt_q;
  // Instructions still to issue, instructions still to commit
  logic [InsnPntWidth:0]   issue_cnt_d, issue_cnt_q;
  logic [InsnPntWidth:0]   commit_cnt_d, commit_cnt_q;

  logic               accept;
  logic               commit;
  logic [NrVInsn-1:0] done_d;

  function automatic logic [InsnPntWidth-1:0] next_pnt(input logic [InsnPntWidth-1:0] pnt);
    if (pnt == InsnQueueDepth - 1) begin
      return '0;
    end
    return pnt + 1'b1;
  endfunction

  // Full once every slot waits for its commit
  assign req_ready_o = (commit_cnt_q != InsnQueueDepth);
  assign accept      = req_valid_i && req_ready_o;
  // Only the instruction at the commit pointer may retire
  assign commit      = commit_done_i && (commit_cnt_q != '0) &&
                       (slot_q[commit_pnt_q].id == commit_id_i);

  always_comb begin
    accept_pnt_d = accept_pnt_q;
    issue_pnt_d  = issue_pnt_q;
    commit_pnt_d = commit_pnt_q;
    issue_cnt_d  = issue_cnt_q;
    commit_cnt_d = commit_cnt_q;
    done_d       = '0;

    // New request takes the slot at the accept pointer
    if (accept) begin
      accept_pnt_d = next_pnt(accept_pnt_q);
      issue_cnt_d  = issue_cnt_d + 1'b1;
      commit_cnt_d = commit_cnt_d + 1'b1;
    end
    // Engine has moved all bytes of the issuing instruction
    if (issue_done_i) begin
      issue_pnt_d = next_pnt(issue_pnt_q);
      issue_cnt_d = issue_cnt_d - 1'b1;
    end
    // Last result word granted
    if (commit) begin
      commit_pnt_d         = next_pnt(commit_pnt_q);
      commit_cnt_d         = commit_cnt_d - 1'b1;
      done_d[commit_id_i]  = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q  <= '0;
      issue_pnt_q   <= '0;
      commit_pnt_q  <= '0;
      issue_cnt_q   <= '0;
      commit_cnt_q  <= '0;
      issue_valid_o <= 1'b0;
      done_o        <= '0;
    end else begin
      accept_pnt_q  <= accept_pnt_d;
      issue_pnt_q   <= issue_pnt_d;
      commit_pnt_q  <= commit_pnt_d;
      issue_cnt_q   <= issue_cnt_d;
      commit_cnt_q  <= commit_cnt_d;
      issue_valid_o <= (issue_cnt_d != '0);
      done_o        <= done_d;
    end
  end

  // Slot storage and the issue copy
  always_ff @(posedge clk_i) begin
    if (accept) begin
      slot_q[accept_pnt_q] <= req_i;
    end
    // Bypass when the request lands straight in the issue slot
    if (accept && (issue_pnt_d == accept_pnt_q)) begin
      issue_req_o <= req_i;
    end else begin
      issue_req_o <= slot_q[issue_pnt_d];
    end
  end

endmodule

//--- source/slide_byte_engine.sv
/*
  Byte engine of the slide unit
  Idle/run FSM with input, output and word pointers
  Byte copy from operand beats into a staging word
  Result word push with address, id and last flag
*/
`timescale 1ns/1ps

module slide_byte_engine (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  sldu_pkg::slide_req_t                     issue_req_i,
  input  logic                                     issue_valid_i,
  output logic                                     issue_done_o,
  input  sldu_pkg::elen_t [sldu_pkg::NrLanes-1:0]  operand_i,
  input  logic                                     operand_valid_i,
  output logic                                     operand_ready_o,
  input  logic                                     rq_full_i,
  output logic                                     rq_push_o,
  output sldu_pkg::elen_t [sldu_pkg::NrLanes-1:0]  rq_wdata_o,
  output sldu_pkg::strb_t [sldu_pkg::NrLanes-1:0]  rq_be_o,
  output sldu_pkg::vaddr_t                         rq_addr_o,
  output sldu_pkg::vid_t                           rq_id_o,
  output logic                                     rq_last_o
);
  import sldu_pkg::*;

  typedef enum logic {
    IDLE,
    RUN
  } state_e;

  state_e state_d, state_q;

  // Byte positions inside the current operand and result words
  bpnt_t  in_pnt_d, in_pnt_q;
  bpnt_t  out_pnt_d, out_pnt_q;
  // Result word index inside the destination register
  vaddr_t word_pnt_d, word_pnt_q;
  // Bytes still to move
  vlen_t  issue_cnt_d, issue_cnt_q;

  // Flat staging word over both lanes, filled step by step
  logic [8*WordBytes-1:0] stage_wdata_d, stage_wdata_q;
  logic [WordBytes-1:0]   stage_be_d, stage_be_q;
  // Staging word merged with this step's bytes
  logic [8*WordBytes-1:0] word_wdata;
  logic [WordBytes-1:0]   word_be;
  logic [8*WordBytes-1:0] operand_flat;

  vlen_t off_bytes;
  vlen_t total_bytes;
  bpnt_t in_left;
  bpnt_t out_left;
  bpnt_t byte_count;
  logic  last_step;

  // Vector byte k of a word sits in lane k/8, byte k mod 8
  assign operand_flat = operand_i;
  assign rq_wdata_o   = word_wdata;
  assign rq_be_o      = word_be;
  assign rq_id_o      = issue_req_i.id;
  assign rq_addr_o    = vaddr_t'(issue_req_i.vd * WordsPerReg) + word_pnt_q;

  // Offset and length in bytes of the issue request
  assign off_bytes   = vlen_t'(issue_req_i.stride << issue_req_i.vsew);
  assign total_bytes = vlen_t'(issue_req_i.vl << issue_req_i.vsew);

  // Bytes moved this step are bounded by both words
  assign in_left    = bpnt_t'(WordBytes) - in_pnt_q;
  assign out_left   = bpnt_t'(WordBytes) - out_pnt_q;
  assign byte_count = (in_left < out_left) ? in_left : out_left;
  assign last_step  = (issue_cnt_q <= vlen_t'(byte_count));

  always_comb begin
    state_d         = state_q;
    in_pnt_d        = in_pnt_q;
    out_pnt_d       = out_pnt_q;
    word_pnt_d      = word_pnt_q;
    issue_cnt_d     = issue_cnt_q;
    word_wdata      = stage_wdata_q;
    word_be         = stage_be_q;
    stage_wdata_d   = stage_wdata_q;
    stage_be_d      = stage_be_q;
    operand_ready_o = 1'b0;
    rq_push_o       = 1'b0;
    rq_last_o       = 1'b0;
    issue_done_o    = 1'b0;

    unique case (state_q)
      IDLE: begin
        if (issue_valid_i) begin
          state_d = RUN;
          if (issue_req_i.op == SLIDE_UP) begin
            // Read from the start and write from the offset on
            issue_cnt_d = total_bytes - off_bytes;
            in_pnt_d    = '0;
            out_pnt_d   = bpnt_t'(off_bytes % WordBytes);
            word_pnt_d  = vaddr_t'(off_bytes / WordBytes);
          end else begin
            // Read from the offset on and write from the start
            issue_cnt_d = total_bytes;
            in_pnt_d    = bpnt_t'(off_bytes % WordBytes);
            out_pnt_d   = '0;
            word_pnt_d  = '0;
          end
        end
      end

      RUN: begin
        // Stall on a missing operand or a full result queue
        if (operand_valid_i && !rq_full_i) begin
          for (int unsigned b = 0; b < WordBytes; b++) begin
            if (b < byte_count && b < issue_cnt_q) begin
              word_wdata[8*(out_pnt_q+b) +: 8] = operand_flat[8*(in_pnt_q+b) +: 8];
              word_be[out_pnt_q+b]             = 1'b1;
            end
          end
          stage_wdata_d = word_wdata;
          stage_be_d    = word_be;
          in_pnt_d      = in_pnt_q + byte_count;
          out_pnt_d     = out_pnt_q + byte_count;
          issue_cnt_d   = issue_cnt_q - vlen_t'(byte_count);

          // Take the next beat once the operand word is used up
          if (in_pnt_d == WordBytes || last_step) begin
            in_pnt_d        = '0;
            operand_ready_o = 1'b1;
          end

          // Hand a complete result word to the result queue
          if (out_pnt_d == WordBytes || last_step) begin
            out_pnt_d     = '0;
            word_pnt_d    = word_pnt_q + 1'b1;
            rq_push_o     = 1'b1;
            stage_wdata_d = '0;
            stage_be_d    = '0;
          end

          if (last_step) begin
            rq_last_o    = 1'b1;
            issue_done_o = 1'b1;
            state_d      = IDLE;
          end
        end
      end

      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= IDLE;
      in_pnt_q    <= '0;
      out_pnt_q   <= '0;
      word_pnt_q  <= '0;
      issue_cnt_q <= '0;
      stage_be_q  <= '0;
    end else begin
      state_q     <= state_d;
      in_pnt_q    <= in_pnt_d;
      out_pnt_q   <= out_pnt_d;
      word_pnt_q  <= word_pnt_d;
      issue_cnt_q <= issue_cnt_d;
      stage_be_q  <= stage_be_d;
    end
  end

  // Staging data register
  always_ff @(posedge clk_i) begin
    stage_wdata_q <= stage_wdata_d;
  end

endmodule

//--- source/slide_result_queue.sv
/*
  Result queue of the slide unit
  Ring of result words with per-lane pending bits
  Lane request/grant tracking and in-order retire
  Commit pulse on the last word of an instruction
*/
`timescale 1ns/1ps

module slide_result_queue (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  logic                                     rq_push_i,
  input  sldu_pkg::elen_t [sldu_pkg::NrLanes-1:0]  rq_wdata_i,
  input  sldu_pkg::strb_t [sldu_pkg::NrLanes-1:0]  rq_be_i,
  input  sldu_pkg::vaddr_t                         rq_addr_i,
  input  sldu_pkg::vid_t                           rq_id_i,
  input  logic                                     rq_last_i,
  output logic                                     rq_full_o,
  output logic            [sldu_pkg::NrLanes-1:0]  result_req_o,
  output sldu_pkg::elen_t [sldu_pkg::NrLanes-1:0]  result_wdata_o,
  output sldu_pkg::strb_t [sldu_pkg::NrLanes-1:0]  result_be_o,
  output sldu_pkg::vaddr_t                         result_addr_o,
  output sldu_pkg::vid_t                           result_id_o,
  input  logic            [sldu_pkg::NrLanes-1:0]  result_gnt_i,
  output logic                                     commit_done_o,
  output sldu_pkg::vid_t                           commit_id_o
);
  import sldu_pkg::*;

  // Entry payload
  elen_t  [ResultQueueDepth-1:0][NrLanes-1:0] wdata_q;
  strb_t  [ResultQueueDepth-1:0][NrLanes-1:0] be_q;
  vaddr_t [ResultQueueDepth-1:0]              addr_q;
  vid_t   [ResultQueueDepth-1:0]              id_q;
  logic   [ResultQueueDepth-1:0]              last_q;

  // Lanes that still owe a grant, per entry
  logic [ResultQueueDepth-1:0][NrLanes-1:0] pending_d, pending_q;
  logic [RqPntWidth-1:0]                    wr_pnt_d, wr_pnt_q;
  logic [RqPntWidth-1:0]                    rd_pnt_d, rd_pnt_q;
  logic [RqPntWidth:0]                      cnt_d, cnt_q;

  logic [NrLanes-1:0] head_left;
  logic               pop;

  function automatic logic [RqPntWidth-1:0] next_pnt(input logic [RqPntWidth-1:0] pnt);
    if (pnt == ResultQueueDepth - 1) begin
      return '0;
    end
    return pnt + 1'b1;
  endfunction

  assign rq_full_o = (cnt_q == ResultQueueDepth);

  // Head entry drives the lanes
  assign result_req_o   = pending_q[rd_pnt_q];
  assign result_wdata_o = wdata_q[rd_pnt_q];
  assign result_be_o    = be_q[rd_pnt_q];
  assign result_addr_o  = addr_q[rd_pnt_q];
  assign result_id_o    = id_q[rd_pnt_q];

  // Head retires in the cycle of its last outstanding grant
  assign head_left     = pending_q[rd_pnt_q] & ~result_gnt_i;
  assign pop           = (cnt_q != '0) && (head_left == '0);
  assign commit_done_o = pop && last_q[rd_pnt_q];
  assign commit_id_o   = id_q[rd_pnt_q];

  always_comb begin
    pending_d           = pending_q;
    wr_pnt_d            = wr_pnt_q;
    rd_pnt_d            = rd_pnt_q;
    cnt_d               = cnt_q;
    pending_d[rd_pnt_q] = head_left;

    if (pop) begin
      rd_pnt_d = next_pnt(rd_pnt_q);
      cnt_d    = cnt_d - 1'b1;
    end
    // A lane with no enabled byte owes nothing
    if (rq_push_i) begin
      for (int unsigned l = 0; l < NrLanes; l++) begin
        pending_d[wr_pnt_q][l] = |rq_be_i[l];
      end
      wr_pnt_d = next_pnt(wr_pnt_q);
      cnt_d    = cnt_d + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= '0;
      wr_pnt_q  <= '0;
      rd_pnt_q  <= '0;
      cnt_q     <= '0;
    end else begin
      pending_q <= pending_d;
      wr_pnt_q  <= wr_pnt_d;
      rd_pnt_q  <= rd_pnt_d;
      cnt_q     <= cnt_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rq_push_i) begin
      wdata_q[wr_pnt_q] <= rq_wdata_i;
      be_q[wr_pnt_q]    <= rq_be_i;
      addr_q[wr_pnt_q]  <= rq_addr_i;
      id_q[wr_pnt_q]    <= rq_id_i;
      last_q[wr_pnt_q]  <= rq_last_i;
    end
  end

endmodule

//--- source/slide_unit.sv
/*
  Slide unit top level
  Instruction queue, byte engine and result queue
*/
`timescale 1ns/1ps

module slide_unit (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  // Sequencer
  input  sldu_pkg::slide_req_t                     req_i,
  input  logic                                     req_valid_i,
  output logic                                     req_ready_o,
  output logic            [sldu_pkg::NrVInsn-1:0]  done_o,
  // Operand stream from the lanes
  input  sldu_pkg::elen_t [sldu_pkg::NrLanes-1:0]  operand_i,
  input  logic                                     operand_valid_i,
  output logic                                     operand_ready_o,
  // Register file writes
  output logic            [sldu_pkg::NrLanes-1:0]  result_req_o,
  output sldu_pkg::elen_t [sldu_pkg::NrLanes-1:0]  result_wdata_o,
  output sldu_pkg::strb_t [sldu_pkg::NrLanes-1:0]  result_be_o,
  output sldu_pkg::vaddr_t                         result_addr_o,
  output sldu_pkg::vid_t                           result_id_o,
  input  logic            [sldu_pkg::NrLanes-1:0]  result_gnt_i
);
  import sldu_pkg::*;

  // Queue to engine
  slide_req_t issue_req;
  logic       issue_valid;
  logic       issue_done;

  // Engine to result queue
  elen_t [NrLanes-1:0] rq_wdata;
  strb_t [NrLanes-1:0] rq_be;
  vaddr_t              rq_addr;
  vid_t                rq_id;
  logic                rq_last;
  logic                rq_push;
  logic                rq_full;

  // Result queue back to the instruction queue
  logic commit_done;
  vid_t commit_id;

  slide_insn_queue slide_insn_queue_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .req_valid_i   (req_valid_i),
    .req_ready_o   (req_ready_o),
    .issue_req_o   (issue_req),
    .issue_valid_o (issue_valid),
    .issue_done_i  (issue_done),
    .commit_done_i (commit_done),
    .commit_id_i   (commit_id),
    .done_o        (done_o)
  );

  slide_byte_engine slide_byte_engine_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .issue_req_i     (issue_req),
    .issue_valid_i   (issue_valid),
    .issue_done_o    (issue_done),
    .operand_i       (operand_i),
    .operand_valid_i (operand_valid_i),
    .operand_ready_o (operand_ready_o),
    .rq_full_i       (rq_full),
    .rq_push_o       (rq_push),
    .rq_wdata_o      (rq_wdata),
    .rq_be_o         (rq_be),
    .rq_addr_o       (rq_addr),
    .rq_id_o         (rq_id),
    .rq_last_o       (rq_last)
  );

  slide_result_queue slide_result_queue_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .rq_push_i      (rq_push),
    .rq_wdata_i     (rq_wdata),
    .rq_be_i        (rq_be),
    .rq_addr_i      (rq_addr),
    .rq_id_i        (rq_id),
    .rq_last_i      (rq_last),
    .rq_full_o      (rq_full),
    .result_req_o   (result_req_o),
    .result_wdata_o (result_wdata_o),
    .result_be_o    (result_be_o),
    .result_addr_o  (result_addr_o),
    .result_id_o    (result_id_o),
    .result_gnt_i   (result_gnt_i),
    .commit_done_o  (commit_done),
    .commit_id_o    (commit_id)
  );

endmodule

//--- bench/tb_slide_model.svh
/*
  Reference model of the slide unit testbench
  Source byte pattern, expected destination bytes
  Test table with one row per instruction
*/
`ifndef TB_SLIDE_MODEL_SVH
`define TB_SLIDE_MODEL_SVH

// Grant behavior of the lanes while a row runs
localparam int GntAlways = 0;
localparam int GntRandom = 1;
localparam int GntHold   = 2;

localparam int NumTests = 12;

typedef struct packed {
  vid_t        id;
  slide_op_e   op;
  elem_width_e vsew;
  vlen_t       vl;
  vlen_t       stride;
  logic [4:0]  vd;
  logic [1:0]  gnt_mode;
} test_row_t;

test_row_t test_table [NumTests];

function automatic test_row_t make_row(
  input int          id,
  input slide_op_e   op,
  input elem_width_e vsew,
  input int          vl,
  input int          stride,
  input int          vd,
  input int          gnt_mode
);
  test_row_t row;
  row.id       = vid_t'(id);
  row.op       = op;
  row.vsew     = vsew;
  row.vl       = vlen_t'(vl);
  row.stride   = vlen_t'(stride);
  row.vd       = 5'(vd);
  row.gnt_mode = 2'(gnt_mode);
  return row;
endfunction

task automatic load_test_table();
  // Slide-up at each element width
  test_table[0]  = make_row(0, SLIDE_UP,   EW8,  40, 5,  1,  GntAlways);
  test_table[1]  = make_row(1, SLIDE_UP,   EW16, 20, 3,  2,  GntAlways);
  test_table[2]  = make_row(2, SLIDE_UP,   EW32, 12, 5,  3,  GntAlways);
  test_table[3]  = make_row(3, SLIDE_UP,   EW64, 8,  3,  4,  GntAlways);
  // Slide-down at each element width
  test_table[4]  = make_row(4, SLIDE_DOWN, EW8,  50, 7,  5,  GntAlways);
  test_table[5]  = make_row(5, SLIDE_DOWN, EW16, 24, 9,  6,  GntAlways);
  test_table[6]  = make_row(6, SLIDE_DOWN, EW32, 16, 1,  7,  GntAlways);
  test_table[7]  = make_row(7, SLIDE_DOWN, EW64, 6,  2,  8,  GntAlways);
  // Random lane grants
  test_table[8]  = make_row(0, SLIDE_UP,   EW16, 30, 11, 9,  GntRandom);
  test_table[9]  = make_row(1, SLIDE_DOWN, EW32, 10, 3,  10, GntRandom);
  // Back to back pair, grants withheld at first
  test_table[10] = make_row(2, SLIDE_UP,   EW8,  64, 17, 11, GntHold);
  test_table[11] = make_row(3, SLIDE_DOWN, EW64, 5,  1,  12, GntHold);
endtask

function automatic int elem_bytes(input int n);
  return 1 << int'(test_table[n].vsew);
endfunction

function automatic int total_bytes(input int n);
  return int'(test_table[n].vl) * elem_bytes(n);
endfunction

function automatic int offset_bytes(input int n);
  return int'(test_table[n].stride) * elem_bytes(n);
endfunction

// Source byte k of instruction n
function automatic logic [7:0] src_byte(input int n, input int k);
  return 8'((k * 29 + n * 11 + 5) % 256);
endfunction

// Destination bytes that the instruction writes
function automatic bit byte_enabled(input int n, input int j);
  if (test_table[n].op == SLIDE_UP) begin
    return (j >= offset_bytes(n)) && (j < total_bytes(n));
  end
  return (j >= 0) && (j < total_bytes(n));
endfunction

function automatic logic [7:0] expected_byte(input int n, input int j);
  if (test_table[n].op == SLIDE_UP) begin
    return src_byte(n, j - offset_bytes(n));
  end
  return src_byte(n, j + offset_bytes(n));
endfunction

function automatic int enabled_count(input int n);
  if (test_table[n].op == SLIDE_UP) begin
    return total_bytes(n) - offset_bytes(n);
  end
  return total_bytes(n);
endfunction

function automatic string test_name(input int n);
  return $sformatf("test%0d_%s_ew%0d", n,
                   (test_table[n].op == SLIDE_UP) ? "up" : "down",
                   8 << int'(test_table[n].vsew));
endfunction

`endif

//--- bench/tb_slide_unit.sv
/*
  Testbench of the slide unit
  Clock, reset, sequencer driver, operand stream and lane grants
  Byte image checks per instruction id, done order checks, watchdog
*/
`timescale 1ns/1ps

module tb_slide_unit;
  import sldu_pkg::*;

  `include "tb_slide_model.svh"

  localparam int RegBytes = WordsPerReg * WordBytes;

  logic                clk_i;
  logic                rst_ni;
  slide_req_t          req_i;
  logic                req_valid_i;
  logic                req_ready_o;
  logic [NrVInsn-1:0]  done_o;
  elen_t [NrLanes-1:0] operand_i;
  logic                operand_valid_i;
  logic                operand_ready_o;
  logic [NrLanes-1:0]  result_req_o;
  elen_t [NrLanes-1:0] result_wdata_o;
  strb_t [NrLanes-1:0] result_be_o;
  vaddr_t              result_addr_o;
  vid_t                result_id_o;
  logic [NrLanes-1:0]  result_gnt_i;

  // Destination register image per instruction id
  logic [7:0] img [NrVInsn][RegBytes];
  bit         written [NrVInsn][RegBytes];
  int         write_cnt [NrVInsn];
  int         row_of_id [NrVInsn];
  int         last_gnt_cycle [NrVInsn];
  // Ids in the order of their done pulses
  int         done_q [$];

  int     cycle_cnt = 0;
  int     error_cnt = 0;
  int     check_cnt = 0;
  int     gnt_mode  = GntHold;
  integer seed      = 70;
  bit     table_loaded = 1'b0;

  slide_unit slide_unit_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_i           (req_i),
    .req_valid_i     (req_valid_i),
    .req_ready_o     (req_ready_o),
    .done_o          (done_o),
    .operand_i       (operand_i),
    .operand_valid_i (operand_valid_i),
    .operand_ready_o (operand_ready_o),
    .result_req_o    (result_req_o),
    .result_wdata_o  (result_wdata_o),
    .result_be_o     (result_be_o),
    .result_addr_o   (result_addr_o),
    .result_id_o     (result_id_o),
    .result_gnt_i    (result_gnt_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  task automatic log_mismatch(input string name, input string what, input int exp, input int act);
    error_cnt++;
    $display("CHECK FAILED %s %s expected %0h actual %0h", name, what, exp, act);
  endtask

  task automatic raise_error(input string msg);
    error_cnt++;
    $display("ERROR %s", msg);
  endtask

  //////////////////////////////
  // Operand stream
  //////////////////////////////

  // Vector byte i of a word sits in lane i/8, byte i mod 8
  function automatic logic [8*WordBytes-1:0] operand_word(input int n, input int w);
    logic [8*WordBytes-1:0] word;
    for (int i = 0; i < WordBytes; i++) begin
      word[8*i +: 8] = src_byte(n, w * int'(WordBytes) + i);
    end
    return word;
  endfunction

  // Slide-down starts reading at the word holding the offset
  function automatic int beat_base(input int n);
    if (test_table[n].op == SLIDE_UP) begin
      return 0;
    end
    return offset_bytes(n) / int'(WordBytes);
  endfunction

  function automatic int beat_count(input int n);
    int first;
    first = (test_table[n].op == SLIDE_UP) ? 0 : offset_bytes(n) % int'(WordBytes);
    return (first + enabled_count(n) + int'(WordBytes) - 1) / int'(WordBytes);
  endfunction

  initial begin : operand_stream
    int base;
    int beats;
    wait (table_loaded && rst_ni);
    @(posedge clk_i);
    for (int n = 0; n < NumTests; n++) begin
      base  = beat_base(n);
      beats = beat_count(n);
      for (int k = 0; k < beats; k++) begin
        operand_i       <= operand_word(n, base + k);
        operand_valid_i <= 1'b1;
        do @(negedge clk_i); while (!operand_ready_o);
        @(posedge clk_i);
      end
    end
    operand_valid_i <= 1'b0;
  end

  // Lane grants
  always @(posedge clk_i) begin
    case (gnt_mode)
      GntAlways: result_gnt_i <= '1;
      GntRandom: result_gnt_i <= NrLanes'($random(seed));
      default:   result_gnt_i <= '0;
    endcase
  end

  //////////////////////////////
  // Result and done monitor
  //////////////////////////////

  always @(negedge clk_i) begin : result_monitor
    int id;
    int n;
    int j;
    for (int l = 0; l < NrLanes; l++) begin
      // A lane write happens on the next rising edge
      if (result_req_o[l] && result_gnt_i[l]) begin
        id = int'(result_id_o);
        n  = row_of_id[id];
        last_gnt_cycle[id] = cycle_cnt;
        check_cnt++;
        if (int'(result_addr_o) / WordsPerReg != int'(test_table[n].vd)) begin
          log_mismatch(test_name(n), "register of address",
                       test_table[n].vd, int'(result_addr_o) / WordsPerReg);
        end
        for (int b = 0; b < LaneBytes; b++) begin
          if (result_be_o[l][b]) begin
            j = int'(result_addr_o) % WordsPerReg * WordBytes + l * LaneBytes + b;
            check_cnt++;
            if (written[id][j]) begin
              raise_error($sformatf("byte %0d of %s was written twice", j, test_name(n)));
            end
            written[id][j] = 1'b1;
            write_cnt[id]++;
            img[id][j] = result_wdata_o[l][8*b +: 8];
            if (!byte_enabled(n, j)) begin
              raise_error($sformatf("byte %0d of %s lies outside the slide", j, test_name(n)));
            end else if (img[id][j] !== expected_byte(n, j)) begin
              log_mismatch(test_name(n), $sformatf("byte %0d", j),
                           expected_byte(n, j), img[id][j]);
            end
          end
        end
      end
    end
    for (int i = 0; i < NrVInsn; i++) begin
      if (done_o[i]) begin
        done_q.push_back(i);
        check_cnt++;
        if (cycle_cnt <= last_gnt_cycle[i]) begin
          raise_error($sformatf("done of id %0d came before its last grant", i));
        end
      end
    end
  end

  //////////////////////////////
  // Sequencer and checks
  //////////////////////////////

  // Called on a rising edge, returns on the edge of acceptance
  task automatic send_request(input int n);
    slide_req_t req;
    int         id;
    id = int'(test_table[n].id);
    for (int j = 0; j < RegBytes; j++) begin
      written[id][j] = 1'b0;
    end
    write_cnt[id]      = 0;
    row_of_id[id]      = n;
    last_gnt_cycle[id] = cycle_cnt;
    req.id     = test_table[n].id;
    req.op     = test_table[n].op;
    req.vsew   = test_table[n].vsew;
    req.vl     = test_table[n].vl;
    req.stride = test_table[n].stride;
    req.vd     = test_table[n].vd;
    req_i       <= req;
    req_valid_i <= 1'b1;
    do @(negedge clk_i); while (!req_ready_o);
    @(posedge clk_i);
  endtask

  task automatic wait_done(input int n);
    int id;
    while (done_q.size() == 0) @(negedge clk_i);
    id = done_q.pop_front();
    check_cnt++;
    if (id != int'(test_table[n].id)) begin
      log_mismatch(test_name(n), "done id", test_table[n].id, id);
    end
    check_cnt++;
    if (write_cnt[test_table[n].id] != enabled_count(n)) begin
      log_mismatch(test_name(n), "enabled bytes", enabled_count(n),
                   write_cnt[test_table[n].id]);
    end
  endtask

  // Two requests back to back while the lanes grant nothing
  task automatic run_withheld_pair(input int n);
    send_request(n);
    send_request(n + 1);
    req_valid_i <= 1'b0;
    @(negedge clk_i);
    check_cnt++;
    if (req_ready_o !== 1'b0) begin
      log_mismatch(test_name(n + 1), "req_ready_o after two acceptances", 0, req_ready_o);
    end
    repeat (40) @(negedge clk_i);
    check_cnt++;
    if (operand_ready_o !== 1'b0) begin
      log_mismatch(test_name(n), "operand_ready_o under back-pressure", 0, operand_ready_o);
    end
    // Beats of the stalled instruction are still waiting
    if (operand_valid_i !== 1'b1) begin
      raise_error("operand stream drained although grants were withheld");
    end
    check_cnt++;
    if (result_req_o === '0) begin
      raise_error("lane requests dropped although no grant was given");
    end
    gnt_mode = GntAlways;
    wait_done(n);
    wait_done(n + 1);
  endtask

  task automatic check_idle();
    check_cnt++;
    if (req_ready_o !== 1'b1) log_mismatch("reset", "req_ready_o", 1, req_ready_o);
    if (result_req_o !== '0) log_mismatch("reset", "result_req_o", 0, result_req_o);
    if (operand_ready_o !== 1'b0) log_mismatch("reset", "operand_ready_o", 0, operand_ready_o);
    if (done_o !== '0) log_mismatch("reset", "done_o", 0, done_o);
  endtask

  initial begin : main_sequence
    int n;
    rst_ni          = 1'b0;
    req_i           = '0;
    req_valid_i     = 1'b0;
    operand_i       = '0;
    operand_valid_i = 1'b0;
    result_gnt_i    = '0;
    for (int i = 0; i < NrVInsn; i++) begin
      write_cnt[i]      = 0;
      row_of_id[i]      = 0;
      last_gnt_cycle[i] = 0;
    end
    load_test_table();
    table_loaded = 1'b1;
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_idle();
    n = 0;
    // Each pass starts on a falling edge
    while (n < NumTests) begin
      gnt_mode = test_table[n].gnt_mode;
      @(posedge clk_i);
      if (test_table[n].gnt_mode == GntHold) begin
        run_withheld_pair(n);
        n = n + 2;
      end else begin
        send_request(n);
        req_valid_i <= 1'b0;
        wait_done(n);
        n = n + 1;
      end
    end
    repeat (10) @(negedge clk_i);
    if (done_q.size() != 0) begin
      raise_error("a done pulse came without a matching request");
    end
    $display("Checks: %0d, errors: %0d", check_cnt, error_cnt);
    if (error_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // Limit grows with the bytes that the table moves
  initial begin : watchdog
    int limit;
    wait (table_loaded);
    limit = 0;
    for (int n = 0; n < NumTests; n++) begin
      limit += total_bytes(n);
    end
    limit = limit * 20 + 200;
    repeat (limit) @(posedge clk_i);
    raise_error("watchdog expired before all instructions completed");
    $display("Checks: %0d, errors: %0d", check_cnt, error_cnt);
    $display("Test failures found");
    $finish;
  end

endmodule

//--- flist.f
+incdir+bench
source/sldu_pkg.sv
source/slide_insn_queue.sv
source/slide_byte_engine.sv
source/slide_result_queue.sv
source/slide_unit.sv
bench/tb_slide_unit.sv
